// ==== Makefile ====
# Verilator build and run for the RV32I ALU pipeline slice.
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_rv_alu_pipe
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
logic/rv_isa_pkg.sv
logic/rv_ctrl_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/forward_unit.sv
logic/id_ex_reg.sv
logic/ex_stage.sv
logic/rv_alu_pipe.sv
testbench/rv_alu_pipe_sva.sv
testbench/tb_rv_alu_pipe.sv

// ==== logic/ex_stage.sv ====
// --------------------
// ALU plus the EX/WB register.
// alu_result_o is combinational and also feeds the EX forward path.
// --------------------
`timescale 1ns/1ps

module ex_stage (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     pc_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     rdata1_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     rdata2_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     imm_i,
  input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] rd_i,
  input  rv_ctrl_pkg::alu_op_e                  alu_op_i,
  input  logic                                  imm_sel_i,
  input  logic                                  auipc_i,
  input  logic                                  lui_i,
  input  logic                                  write_en_i,
  output logic [rv_isa_pkg::WORD_WIDTH-1:0]     alu_result_o,
  output logic                                  wb_we_o,
  output logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] wb_rd_o,
  output logic [rv_isa_pkg::WORD_WIDTH-1:0]     wb_data_o
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [WORD_WIDTH-1:0] op_a;
  logic [WORD_WIDTH-1:0] op_b;
  logic [4:0]            shamt;

  assign op_a  = auipc_i ? pc_i : (lui_i ? '0 : rdata1_i);
  assign op_b  = imm_sel_i ? imm_i : rdata2_i;
  assign shamt = op_b[4:0]; // RV32 shifts ignore the upper bits.

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_result_o = op_a + op_b;
      ALU_SUB:  alu_result_o = op_a - op_b;
      ALU_AND:  alu_result_o = op_a & op_b;
      ALU_OR:   alu_result_o = op_a | op_b;
      ALU_XOR:  alu_result_o = op_a ^ op_b;
      ALU_SLL:  alu_result_o = op_a << shamt;
      ALU_SRL:  alu_result_o = op_a >> shamt;
      ALU_SRA:  alu_result_o = $unsigned($signed(op_a) >>> shamt);
      ALU_SLT:  alu_result_o = {{(WORD_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result_o = {{(WORD_WIDTH-1){1'b0}}, op_a < op_b};
      default:  alu_result_o = op_a + op_b; // Unused codes.
    endcase
  end

  // EX/WB payload.
  always_ff @(posedge clk) begin
    wb_rd_o   <= rd_i;
    wb_data_o <= alu_result_o;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_we_o <= 1'b0;
    end else begin
      wb_we_o <= write_en_i;
    end
  end

endmodule

// ==== logic/forward_unit.sv ====
// --------------------
// Forward select for both operands, EX before WB.
// Relies on write enables already low for x0.
// --------------------
`timescale 1ns/1ps

module forward_unit (
  input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] rs1_i,
  input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] rs2_i,
  input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] ex_rd_i,
  input  logic                                  ex_we_i,
  input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] wb_rd_i,
  input  logic                                  wb_we_i,
  output logic                                  fwd_a_ex_o,
  output logic                                  fwd_a_wb_o,
  output logic                                  fwd_b_ex_o,
  output logic                                  fwd_b_wb_o
);

  logic a_hit_ex;
  logic a_hit_wb;
  logic b_hit_ex;
  logic b_hit_wb;

  assign a_hit_ex = ex_we_i && (ex_rd_i == rs1_i);
  assign a_hit_wb = wb_we_i && (wb_rd_i == rs1_i);
  assign b_hit_ex = ex_we_i && (ex_rd_i == rs2_i);
  assign b_hit_wb = wb_we_i && (wb_rd_i == rs2_i);

  // The newer EX result masks an older WB match.
  assign fwd_a_ex_o = a_hit_ex;
  assign fwd_a_wb_o = a_hit_wb && !a_hit_ex;
  assign fwd_b_ex_o = b_hit_ex;
  assign fwd_b_wb_o = b_hit_wb && !b_hit_ex;

endmodule

// ==== logic/id_ex_reg.sv ====
// --------------------
// ID/EX register, operands forwarded on the way in.
// clear_i drops the write enable, so a bubble never writes back.
// --------------------
`timescale 1ns/1ps

module id_ex_reg (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic                                  clear_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     pc_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     rdata1_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     rdata2_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     imm_i,
  input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] rd_i,
  input  rv_ctrl_pkg::alu_op_e                  alu_op_i,
  input  logic                                  imm_sel_i,
  input  logic                                  auipc_i,
  input  logic                                  lui_i,
  input  logic                                  write_en_i,
  output logic [rv_isa_pkg::WORD_WIDTH-1:0]     pc_o,
  output logic [rv_isa_pkg::WORD_WIDTH-1:0]     rdata1_o,
  output logic [rv_isa_pkg::WORD_WIDTH-1:0]     rdata2_o,
  output logic [rv_isa_pkg::WORD_WIDTH-1:0]     imm_o,
  output logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] rd_o,
  output rv_ctrl_pkg::alu_op_e                  alu_op_o,
  output logic                                  imm_sel_o,
  output logic                                  auipc_o,
  output logic                                  lui_o,
  output logic                                  write_en_o,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     ex_data_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     wb_data_i,
  input  logic                                  fwd_a_ex_i,
  input  logic                                  fwd_a_wb_i,
  input  logic                                  fwd_b_ex_i,
  input  logic                                  fwd_b_wb_i
);

  import rv_isa_pkg::*;

  logic [WORD_WIDTH-1:0] opa_sel;
  logic [WORD_WIDTH-1:0] opb_sel;

  // Operand A source.
  always_comb begin
    if (fwd_a_ex_i) begin
      opa_sel = ex_data_i;      // Result of the instruction now in EX.
    end else if (fwd_a_wb_i) begin
      opa_sel = wb_data_i;      // Result waiting in EX/WB.
    end else begin
      opa_sel = rdata1_i;
    end
  end

  // Operand B source, same priority.
  always_comb begin
    if (fwd_b_ex_i) begin
      opb_sel = ex_data_i;
    end else if (fwd_b_wb_i) begin
      opb_sel = wb_data_i;
    end else begin
      opb_sel = rdata2_i;
    end
  end

  always_ff @(posedge clk) begin
    pc_o      <= pc_i;
    rdata1_o  <= opa_sel;
    rdata2_o  <= opb_sel;
    imm_o     <= imm_i;
    rd_o      <= rd_i;
    alu_op_o  <= alu_op_i;
    imm_sel_o <= imm_sel_i;
    auipc_o   <= auipc_i;
    lui_o     <= lui_i;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      write_en_o <= 1'b0;
    end else begin
      write_en_o <= write_en_i && !clear_i;
    end
  end

endmodule

// ==== logic/instr_decoder.sv ====
// --------------------
// Combinational decode of OP, OP-IMM, LUI and AUIPC.
// Any other opcode decodes with write_en_o low.
// --------------------
`timescale 1ns/1ps

module instr_decoder (
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     instr_i,
  output logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] rs1_o,
  output logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] rs2_o,
  output logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] rd_o,
  output logic [rv_isa_pkg::WORD_WIDTH-1:0]     imm_o,
  output rv_ctrl_pkg::alu_op_e                  alu_op_o,
  output logic                                  imm_sel_o,
  output logic                                  auipc_o,
  output logic                                  lui_o,
  output logic                                  write_en_o
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  alt_sel;
  logic                  legal;
  logic [WORD_WIDTH-1:0] imm_i_type;
  logic [WORD_WIDTH-1:0] imm_u_type;
  alu_op_e               base_op;

  assign opcode  = instr_i[6:0];
  assign funct3  = instr_i[14:12];
  assign funct7  = instr_i[31:25];
  assign alt_sel = (funct7 == F7_ALT);

  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20]; // Part of the immediate for OP-IMM, unused there.
  assign rd_o  = instr_i[11:7];

  assign imm_i_type = {{(WORD_WIDTH-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  // Operation from funct3, shared by register and immediate forms.
  always_comb begin
    case (funct3)
      F3_ADD_SUB: base_op = (alt_sel && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
      F3_SLL:     base_op = ALU_SLL;
      F3_SLT:     base_op = ALU_SLT;
      F3_SLTU:    base_op = ALU_SLTU;
      F3_XOR:     base_op = ALU_XOR;
      F3_SRL_SRA: base_op = alt_sel ? ALU_SRA : ALU_SRL; // SRAI too.
      F3_OR:      base_op = ALU_OR;
      F3_AND:     base_op = ALU_AND;
    endcase
  end

  always_comb begin
    alu_op_o  = ALU_ADD;
    imm_o     = imm_i_type;
    imm_sel_o = 1'b0;
    auipc_o   = 1'b0;
    lui_o     = 1'b0;
    legal     = 1'b1;
    case (opcode)
      OPC_OP: begin
        alu_op_o = base_op;
      end
      OPC_OP_IMM: begin
        alu_op_o  = base_op;
        imm_sel_o = 1'b1;
      end
      OPC_LUI: begin
        imm_o     = imm_u_type;
        imm_sel_o = 1'b1;
        lui_o     = 1'b1; // Operand A forced to zero in EX.
      end
      OPC_AUIPC: begin
        imm_o     = imm_u_type;
        imm_sel_o = 1'b1;
        auipc_o   = 1'b1;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  // No writeback for unknown opcodes or x0.
  assign write_en_o = legal && (rd_o != '0);

endmodule

// ==== logic/reg_file.sv ====
// --------------------
// 32x32 register file, x0 reads zero.
// Reads are combinational with no write bypass.
// --------------------
`timescale 1ns/1ps

module reg_file (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] raddr1_i,
  input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] raddr2_i,
  output logic [rv_isa_pkg::WORD_WIDTH-1:0]     rdata1_o,
  output logic [rv_isa_pkg::WORD_WIDTH-1:0]     rdata2_o,
  input  logic                                  we_i,
  input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     wdata_i
);

  import rv_isa_pkg::*;

  // Only x1..x31 are stored.
  logic [WORD_WIDTH-1:0] regs [1:(2**REG_ADDR_WIDTH)-1];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 2**REG_ADDR_WIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== logic/rv_alu_pipe.sv ====
// --------------------
// Decode-to-writeback ALU slice, two-edge latency.
// No stall input, so a new instruction may issue every cycle.
// --------------------
`timescale 1ns/1ps

module rv_alu_pipe (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic                                  instr_valid_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     instr_i,
  input  logic [rv_isa_pkg::WORD_WIDTH-1:0]     pc_i,
  output logic                                  wb_valid_o,
  output logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] wb_rd_o,
  output logic [rv_isa_pkg::WORD_WIDTH-1:0]     wb_data_o
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [REG_ADDR_WIDTH-1:0] dec_rs1;
  logic [REG_ADDR_WIDTH-1:0] dec_rs2;
  logic [REG_ADDR_WIDTH-1:0] dec_rd;
  logic [WORD_WIDTH-1:0]     dec_imm;
  alu_op_e                   dec_alu_op;
  logic                      dec_imm_sel;
  logic                      dec_auipc;
  logic                      dec_lui;
  logic                      dec_we;
  logic [WORD_WIDTH-1:0]     rf_rdata1;
  logic [WORD_WIDTH-1:0]     rf_rdata2;
  logic                      fwd_a_ex;
  logic                      fwd_a_wb;
  logic                      fwd_b_ex;
  logic                      fwd_b_wb;
  logic                      bubble;
  logic [WORD_WIDTH-1:0]     ex_pc;
  logic [WORD_WIDTH-1:0]     ex_rdata1;
  logic [WORD_WIDTH-1:0]     ex_rdata2;
  logic [WORD_WIDTH-1:0]     ex_imm;
  logic [REG_ADDR_WIDTH-1:0] ex_rd;
  alu_op_e                   ex_alu_op;
  logic                      ex_imm_sel;
  logic                      ex_auipc;
  logic                      ex_lui;
  logic                      ex_we;
  logic [WORD_WIDTH-1:0]     alu_result;

  assign bubble = ~instr_valid_i; // Empty slot enters ID/EX with write enable low.

  instr_decoder u_instr_decoder (
    .instr_i(instr_i), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd), .imm_o(dec_imm),
    .alu_op_o(dec_alu_op), .imm_sel_o(dec_imm_sel), .auipc_o(dec_auipc), .lui_o(dec_lui),
    .write_en_o(dec_we)
  );

  // Written from EX/WB, the same values that leave on the wb ports.
  reg_file u_reg_file (
    .clk(clk), .rst_n_i(rst_n_i), .raddr1_i(dec_rs1), .raddr2_i(dec_rs2),
    .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2),
    .we_i(wb_valid_o), .waddr_i(wb_rd_o), .wdata_i(wb_data_o)
  );

  forward_unit u_forward_unit (
    .rs1_i(dec_rs1), .rs2_i(dec_rs2), .ex_rd_i(ex_rd), .ex_we_i(ex_we),
    .wb_rd_i(wb_rd_o), .wb_we_i(wb_valid_o),
    .fwd_a_ex_o(fwd_a_ex), .fwd_a_wb_o(fwd_a_wb), .fwd_b_ex_o(fwd_b_ex), .fwd_b_wb_o(fwd_b_wb)
  );

  id_ex_reg u_id_ex_reg (
    .clk(clk), .rst_n_i(rst_n_i), .clear_i(bubble),
    .pc_i(pc_i), .rdata1_i(rf_rdata1), .rdata2_i(rf_rdata2), .imm_i(dec_imm), .rd_i(dec_rd),
    .alu_op_i(dec_alu_op), .imm_sel_i(dec_imm_sel), .auipc_i(dec_auipc), .lui_i(dec_lui),
    .write_en_i(dec_we),
    .pc_o(ex_pc), .rdata1_o(ex_rdata1), .rdata2_o(ex_rdata2), .imm_o(ex_imm), .rd_o(ex_rd),
    .alu_op_o(ex_alu_op), .imm_sel_o(ex_imm_sel), .auipc_o(ex_auipc), .lui_o(ex_lui),
    .write_en_o(ex_we),
    .ex_data_i(alu_result), .wb_data_i(wb_data_o),
    .fwd_a_ex_i(fwd_a_ex), .fwd_a_wb_i(fwd_a_wb), .fwd_b_ex_i(fwd_b_ex), .fwd_b_wb_i(fwd_b_wb)
  );

  ex_stage u_ex_stage (
    .clk(clk), .rst_n_i(rst_n_i), .pc_i(ex_pc), .rdata1_i(ex_rdata1), .rdata2_i(ex_rdata2),
    .imm_i(ex_imm), .rd_i(ex_rd), .alu_op_i(ex_alu_op), .imm_sel_i(ex_imm_sel),
    .auipc_i(ex_auipc), .lui_i(ex_lui), .write_en_i(ex_we),
    .alu_result_o(alu_result), .wb_we_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

endmodule

// ==== logic/rv_ctrl_pkg.sv ====
// --------------------
// Control encodings passed from decode to execute.
// --------------------
package rv_ctrl_pkg;

  localparam int ALU_OP_WIDTH = 4;

  // ALU operations. Six codes of the 4-bit space are unused.
  typedef enum logic [ALU_OP_WIDTH-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8, // Signed compare.
    ALU_SLTU = 4'd9  // Unsigned compare.
  } alu_op_e;

endpackage

// ==== logic/rv_isa_pkg.sv ====
// --------------------
// RV32I base encodings used by the ALU slice only.
// No load, store, branch or system opcodes here.
// --------------------
package rv_isa_pkg;

  // Datapath and register index widths.
  localparam int WORD_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;

  // Major opcodes, bits [6:0].
  localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU.
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate ALU.
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // Function codes, bits [14:12].
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Bits [31:25] that turn ADD into SUB and a logical right shift into
  // an arithmetic one. Also selects SRAI in the immediate form.
  localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

// ==== testbench/rv_alu_pipe_sva.sv ====
// --------------------
// Port-level checks for rv_alu_pipe, attached by bind.
// Assumes the fixed two-edge issue-to-writeback latency.
// --------------------
`timescale 1ns/1ps

module rv_alu_pipe_sva (
  input logic                                  clk,
  input logic                                  rst_n_i,
  input logic                                  instr_valid_i,
  input logic                                  wb_valid_o,
  input logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] wb_rd_o
);

  int err_cnt = 0; // Failed assertions so far.

  // EX/WB write enable is held in reset.
  a_quiet_in_reset : assert property (
    @(posedge clk) !rst_n_i |-> !wb_valid_o
  ) else begin
    $error("wb_valid_o is high while reset is held");
    err_cnt++;
  end

  // Every writeback comes from a strobe two edges back.
  a_wb_from_issue : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    wb_valid_o |-> $past(instr_valid_i, 2)
  ) else begin
    $error("wb_valid_o without an instruction strobe two cycles before");
    err_cnt++;
  end

  a_wb_rd_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    wb_valid_o |-> (wb_rd_o != '0)
  ) else begin
    $error("writeback to x0 reported on wb_rd_o");
    err_cnt++;
  end

endmodule

// ==== testbench/tb_rv_alu_pipe.sv ====
// --------------------
// Table-driven test of rv_alu_pipe from a zero register file.
// Each entry is checked two edges after it is driven.
// --------------------
`timescale 1ns/1ps

module tb_rv_alu_pipe;

  import rv_isa_pkg::*;

  localparam int          PERIOD         = 40;
  localparam int          DRIVE_DLY      = 2;
  localparam logic [31:0] SEED           = 32'haa19;
  localparam int          NUM_TESTS      = 34;
  localparam int          TIMEOUT_MARGIN = 10;

  logic                      clk;
  logic                      rst_n_i;
  logic                      instr_valid_i;
  logic [WORD_WIDTH-1:0]     instr_i;
  logic [WORD_WIDTH-1:0]     pc_i;
  logic                      wb_valid_o;
  logic [REG_ADDR_WIDTH-1:0] wb_rd_o;
  logic [WORD_WIDTH-1:0]     wb_data_o;

  logic                      tbl_valid [NUM_TESTS];
  logic [WORD_WIDTH-1:0]     tbl_instr [NUM_TESTS];
  logic [WORD_WIDTH-1:0]     tbl_pc    [NUM_TESTS];
  logic                      tbl_we    [NUM_TESTS];
  logic [REG_ADDR_WIDTH-1:0] tbl_rd    [NUM_TESTS];
  logic [WORD_WIDTH-1:0]     tbl_data  [NUM_TESTS];
  int                        n_loaded;
  int                        pass_cnt;
  int                        fail_cnt;
  logic [WORD_WIDTH-1:0]     auipc_pc;

  rv_alu_pipe u_rv_alu_pipe (
    .clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .pc_i(pc_i), .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

  bind rv_alu_pipe rv_alu_pipe_sva u_rv_alu_pipe_sva (
    .clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i),
    .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o)
  );

  // RV32I field packing.
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [19:0] imm,
                                         input logic [4:0] rd);
    return {imm, rd, opc};
  endfunction

  task automatic add_entry(input logic v, input logic [31:0] ins, input logic [31:0] pc,
                           input logic we, input logic [4:0] rd, input logic [31:0] data);
    tbl_valid[n_loaded] = v;
    tbl_instr[n_loaded] = ins;
    tbl_pc[n_loaded]    = pc;
    tbl_we[n_loaded]    = we;
    tbl_rd[n_loaded]    = rd;
    tbl_data[n_loaded]  = data;
    n_loaded++;
  endtask

  task automatic build_table();
    auipc_pc = $urandom();
    auipc_pc[1:0] = 2'b00; // Word aligned.
    add_entry(1'b0, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
    add_entry(1'b0, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
    add_entry(1'b1, i_type(12'd100, 5'd0, F3_ADD_SUB, 5'd1), 32'h0, 1'b1, 5'd1, 32'd100);
    add_entry(1'b1, i_type(12'hFF9, 5'd0, F3_ADD_SUB, 5'd2), 32'h0, 1'b1, 5'd2, 32'hFFFF_FFF9);
    add_entry(1'b1, i_type(12'd5, 5'd0, F3_ADD_SUB, 5'd3), 32'h0, 1'b1, 5'd3, 32'd5);
    add_entry(1'b0, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
    add_entry(1'b0, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
    // Independent ops, all sources from the register file.
    add_entry(1'b1, r_type(F7_ALT, 5'd3, 5'd1, F3_ADD_SUB, 5'd4), 32'h0, 1'b1, 5'd4, 32'h5F);
    add_entry(1'b1, r_type(F7_ALT, 5'd3, 5'd2, F3_SRL_SRA, 5'd5), 32'h0, 1'b1, 5'd5, 32'hFFFF_FFFF);
    add_entry(1'b1, i_type({F7_ALT, 5'd1}, 5'd2, F3_SRL_SRA, 5'd6), 32'h0, 1'b1, 5'd6,
              32'hFFFF_FFFC);
    add_entry(1'b1, r_type(7'd0, 5'd1, 5'd2, F3_SLT, 5'd8), 32'h0, 1'b1, 5'd8, 32'd1);
    add_entry(1'b1, r_type(7'd0, 5'd1, 5'd2, F3_SLTU, 5'd9), 32'h0, 1'b1, 5'd9, 32'd0);
    add_entry(1'b1, r_type(7'd0, 5'd2, 5'd1, F3_XOR, 5'd10), 32'h0, 1'b1, 5'd10, 32'hFFFF_FF9D);
    add_entry(1'b1, r_type(7'd0, 5'd3, 5'd3, F3_SLL, 5'd13), 32'h0, 1'b1, 5'd13, 32'hA0);
    add_entry(1'b1, i_type(12'd28, 5'd2, F3_SRL_SRA, 5'd20), 32'h0, 1'b1, 5'd20, 32'hF);
    add_entry(1'b1, i_type(12'h0F0, 5'd2, F3_AND, 5'd17), 32'h0, 1'b1, 5'd17, 32'hF0);
    // Back-to-back dependences through the EX path.
    add_entry(1'b1, i_type(12'd10, 5'd0, F3_ADD_SUB, 5'd21), 32'h0, 1'b1, 5'd21, 32'd10);
    add_entry(1'b1, r_type(7'd0, 5'd3, 5'd21, F3_ADD_SUB, 5'd22), 32'h0, 1'b1, 5'd22, 32'd15);
    add_entry(1'b1, r_type(F7_ALT, 5'd22, 5'd1, F3_ADD_SUB, 5'd23), 32'h0, 1'b1, 5'd23, 32'h55);
    add_entry(1'b1, r_type(7'd0, 5'd23, 5'd23, F3_ADD_SUB, 5'd24), 32'h0, 1'b1, 5'd24, 32'hAA);
    // Two apart uses WB, three apart the register file.
    add_entry(1'b1, i_type(12'd7, 5'd0, F3_ADD_SUB, 5'd25), 32'h0, 1'b1, 5'd25, 32'd7);
    add_entry(1'b1, i_type(12'd9, 5'd0, F3_ADD_SUB, 5'd26), 32'h0, 1'b1, 5'd26, 32'd9);
    add_entry(1'b1, r_type(7'd0, 5'd1, 5'd25, F3_ADD_SUB, 5'd27), 32'h0, 1'b1, 5'd27, 32'h6B);
    add_entry(1'b1, r_type(7'd0, 5'd26, 5'd25, F3_ADD_SUB, 5'd28), 32'h0, 1'b1, 5'd28, 32'h10);
    add_entry(1'b1, i_type(12'd1, 5'd0, F3_ADD_SUB, 5'd29), 32'h0, 1'b1, 5'd29, 32'd1);
    add_entry(1'b1, i_type(12'd2, 5'd0, F3_ADD_SUB, 5'd29), 32'h0, 1'b1, 5'd29, 32'd2);
    add_entry(1'b1, i_type(12'd0, 5'd29, F3_ADD_SUB, 5'd30), 32'h0, 1'b1, 5'd30, 32'd2);
    add_entry(1'b1, u_type(OPC_LUI, 20'h12345, 5'd31), 32'h0, 1'b1, 5'd31, 32'h1234_5000);
    add_entry(1'b1, u_type(OPC_AUIPC, 20'h00010, 5'd5), auipc_pc, 1'b1, 5'd5,
              auipc_pc + 32'h0001_0000);
    // Bubble, a load opcode and an x0 target must stay silent.
    add_entry(1'b0, i_type(12'd1, 5'd0, F3_ADD_SUB, 5'd7), 32'h0, 1'b0, 5'd0, 32'h0);
    add_entry(1'b1, 32'h0000_A283, 32'h0, 1'b0, 5'd0, 32'h0);
    add_entry(1'b1, i_type(12'd55, 5'd1, F3_ADD_SUB, 5'd0), 32'h0, 1'b0, 5'd0, 32'h0);
    add_entry(1'b1, r_type(7'd0, 5'd5, 5'd0, F3_ADD_SUB, 5'd8), 32'h0, 1'b1, 5'd8,
              auipc_pc + 32'h0001_0000);
    add_entry(1'b0, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0);
  endtask

  task automatic check_entry(input int idx);
    logic ok;
    ok = 1'b1;
    assert (wb_valid_o === tbl_we[idx]) else begin
      $display("ERROR t=%0t wb_valid_o got %0b exp %0b", $time, wb_valid_o, tbl_we[idx]);
      ok = 1'b0;
    end
    if (tbl_we[idx]) begin
      assert (wb_rd_o === tbl_rd[idx]) else begin
        $display("ERROR t=%0t wb_rd_o got %0d exp %0d", $time, wb_rd_o, tbl_rd[idx]);
        ok = 1'b0;
      end
      assert (wb_data_o === tbl_data[idx]) else begin
        $display("ERROR t=%0t wb_data_o got 0x%08h exp 0x%08h", $time, wb_data_o,
                 tbl_data[idx]);
        ok = 1'b0;
      end
    end
    if (ok) pass_cnt++;
    else fail_cnt++;
    $display("test %0d %s", idx, ok ? "pass" : "fail");
  endtask

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Ends a hung run.
  initial begin
    #((NUM_TESTS + TIMEOUT_MARGIN) * PERIOD);
    $display("Timeout: the test sequence did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [31:0] seed_ret;
    seed_ret = $urandom(SEED);
    rst_n_i = 1'b1;
    instr_valid_i = 1'b0;
    instr_i = '0;
    pc_i = '0;
    n_loaded = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    build_table();
    #5 rst_n_i = 1'b0; // Falling edge starts the async reset.
    repeat (2) @(posedge clk);
    #DRIVE_DLY rst_n_i = 1'b1;
    for (int i = 0; i < NUM_TESTS + 2; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      if (i >= 2) check_entry(i - 2);
      if (i < NUM_TESTS) begin
        instr_valid_i = tbl_valid[i];
        instr_i       = tbl_instr[i];
        pc_i          = tbl_pc[i];
      end else begin
        instr_valid_i = 1'b0; // Drain.
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d", n_loaded,
             pass_cnt, fail_cnt, u_rv_alu_pipe.u_rv_alu_pipe_sva.err_cnt);
    if (fail_cnt == 0 && u_rv_alu_pipe.u_rv_alu_pipe_sva.err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
